/* hdl/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

	// byte address as seen by the load/store unit
	localparam int unsigned ADDR_W = 32;

	// one cache line, also the width of the external memory bus
	localparam int unsigned LINE_W = 128;

	// direct-mapped geometry
	localparam int unsigned IDX_W = 4;
	localparam int unsigned DC_LINES = 1 << IDX_W;

	// 16 bytes per line, four words
	localparam int unsigned OFS_W = 4;

	// whatever is left above index and offset
	localparam int unsigned TAG_W = ADDR_W - IDX_W - OFS_W;

	// region decode on the top address nibble
	localparam int unsigned REGION_MSB = 31;

	// only region 0 goes through the cache, everything else is device space
	localparam logic [3:0] CACHED_REGION = 4'h0;

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	// integer register and data path width
	localparam int unsigned XLEN = 32;

	// x0..x31
	localparam int unsigned REG_IDX_W = 5;

	// source of the register writeback value
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_t;

endpackage

`default_nettype wire

/* hdl/dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache (
	input  wire logic                        clk_i,
	input  wire logic                        rst_ni,
	input  wire logic                        req_valid_i,
	input  wire logic                        req_we_i,
	input  wire logic [dmem_pkg::ADDR_W-1:0] req_addr_i,
	input  wire logic [pipe_pkg::XLEN-1:0]   req_wdata_i,
	output logic                             ready_o,
	output logic [pipe_pkg::XLEN-1:0]        rdata_o,
	output logic                             bus_req_o,
	output logic                             bus_we_o,
	output logic [dmem_pkg::ADDR_W-1:0]      bus_addr_o,
	output logic [dmem_pkg::LINE_W-1:0]      bus_wdata_o,
	input  wire logic                        bus_rvalid_i,
	input  wire logic [dmem_pkg::LINE_W-1:0] bus_rdata_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WB,
		S_REFILL
	} state_e;

	state_e state_q;
	state_e state_d;

	logic [dmem_pkg::DC_LINES-1:0] valid_q;
	logic [dmem_pkg::DC_LINES-1:0] dirty_q;
	logic [dmem_pkg::TAG_W-1:0]    tag_q  [dmem_pkg::DC_LINES];
	logic [dmem_pkg::LINE_W-1:0]   line_q [dmem_pkg::DC_LINES];

	logic [dmem_pkg::TAG_W-1:0] tag;
	logic [dmem_pkg::IDX_W-1:0] idx;
	logic [dmem_pkg::OFS_W-3:0] word_sel;
	logic                       hit;
	logic                       wr_hit;
	logic                       refill_done;

	// address split: tag | index | byte offset
	assign tag = req_addr_i[dmem_pkg::ADDR_W-1 -: dmem_pkg::TAG_W];
	assign idx = req_addr_i[dmem_pkg::OFS_W +: dmem_pkg::IDX_W];
	// word within the line, bits 1:0 are always zero for word access
	assign word_sel = req_addr_i[dmem_pkg::OFS_W-1:2];

	assign hit = valid_q[idx] && (tag_q[idx] == tag);
	assign ready_o = req_valid_i && (state_q == S_IDLE) && hit;
	assign wr_hit = ready_o && req_we_i;
	assign refill_done = (state_q == S_REFILL) && bus_rvalid_i;

	assign rdata_o = line_q[idx][word_sel*pipe_pkg::XLEN +: pipe_pkg::XLEN];

	// bus side, held for the whole state
	assign bus_req_o = (state_q != S_IDLE);
	assign bus_we_o = (state_q == S_WB);
	// victim line address on writeback, requested line on refill
	assign bus_addr_o = (state_q == S_WB) ?
		{tag_q[idx], idx, {dmem_pkg::OFS_W{1'b0}}} :
		{tag, idx, {dmem_pkg::OFS_W{1'b0}}};
	assign bus_wdata_o = line_q[idx];

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (req_valid_i && !hit) begin
					// dirty victim must reach memory before the refill
					state_d = (valid_q[idx] && dirty_q[idx]) ? S_WB : S_REFILL;
				end
			end
			S_WB: begin
				// memory takes a write in one cycle
				state_d = S_REFILL;
			end
			S_REFILL: begin
				if (bus_rvalid_i) begin
					state_d = S_IDLE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= S_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			state_q <= state_d;
			if (refill_done) begin
				valid_q[idx] <= 1'b1;
				dirty_q[idx] <= 1'b0;
			end else if (wr_hit) begin
				dirty_q[idx] <= 1'b1;
			end
		end
	end

	// tag and line storage
	always_ff @(posedge clk_i) begin
		if (refill_done) begin
			tag_q[idx]  <= tag;
			line_q[idx] <= bus_rdata_i;
		end else if (wr_hit) begin
			line_q[idx][word_sel*pipe_pkg::XLEN +: pipe_pkg::XLEN] <= req_wdata_i;
		end
	end

	// the refilled line must hit on the next cycle
	a_refill_hits: assert property (@(posedge clk_i) disable iff (!rst_ni)
		refill_done |=> !req_valid_i || ready_o);

	// only a valid dirty line is ever written back
	a_wb_dirty_victim: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_we_o |-> valid_q[idx] && dirty_q[idx]);

endmodule

`default_nettype wire

/* hdl/uncached_port.sv */
`timescale 1ns/100ps
`default_nettype none

module uncached_port (
	input  wire logic                        clk_i,
	input  wire logic                        rst_ni,
	input  wire logic                        req_valid_i,
	input  wire logic                        req_we_i,
	input  wire logic                        bus_rvalid_i,
	input  wire logic [dmem_pkg::LINE_W-1:0] bus_rdata_i,
	output logic                             bus_req_o,
	output logic                             bus_we_o,
	output logic                             done_o,
	output logic [pipe_pkg::XLEN-1:0]        rdata_o
);

	logic                      pend_q;
	logic [pipe_pkg::XLEN-1:0] rdata_q;
	logic                      rd_ret;

	// read data comes back on the low word of the bus
	assign rd_ret = req_valid_i && !req_we_i && !pend_q && bus_rvalid_i;

	// writes are fire and forget, reads hold the request until data returns
	assign bus_req_o = req_valid_i && (req_we_i || !pend_q);
	assign bus_we_o = req_valid_i && req_we_i;
	assign done_o = req_valid_i && (req_we_i || pend_q || rd_ret);
	assign rdata_o = pend_q ? rdata_q : bus_rdata_i[pipe_pkg::XLEN-1:0];

	// pending stays set until the request goes away
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pend_q <= 1'b0;
		end else if (!req_valid_i) begin
			pend_q <= 1'b0;
		end else if (rd_ret) begin
			pend_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_ret) begin
			rdata_q <= bus_rdata_i[pipe_pkg::XLEN-1:0];
		end
	end

	// captured read data holds while the request stays
	a_read_data_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
		done_o && !req_we_i |=> !req_valid_i || $stable(rdata_o));

endmodule

`default_nettype wire

/* hdl/mem_stage_join.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_join (
	input  wire logic                           clk_i,
	input  wire logic                           rst_ni,
	input  wire logic                           enable_i,
	input  wire logic                           flush_i,
	input  wire logic                           access_i,
	input  wire logic                           cached_i,
	input  wire logic [dmem_pkg::ADDR_W-1:0]    addr_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      wdata_i,
	input  wire logic                           dc_bus_req_i,
	input  wire logic                           dc_bus_we_i,
	input  wire logic [dmem_pkg::ADDR_W-1:0]    dc_bus_addr_i,
	input  wire logic [dmem_pkg::LINE_W-1:0]    dc_bus_wdata_i,
	input  wire logic                           dc_ready_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      dc_rdata_i,
	input  wire logic                           uc_bus_req_i,
	input  wire logic                           uc_bus_we_i,
	input  wire logic                           uc_done_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      uc_rdata_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      alu_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      pc4_i,
	input  wire pipe_pkg::wb_sel_t              wbsel_i,
	input  wire logic                           regwen_i,
	input  wire logic [pipe_pkg::REG_IDX_W-1:0] rd_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      inst_i,
	input  wire logic                           csr_we_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      csr_waddr_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      csr_rdata_i,
	output logic                                cs_o,
	output logic                                we_o,
	output logic [dmem_pkg::ADDR_W-1:0]         addr_o,
	output logic [dmem_pkg::LINE_W-1:0]         wdata_o,
	output logic                                stall_o,
	output logic [pipe_pkg::XLEN-1:0]           alu_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           pc4_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           mem_wb_o,
	output pipe_pkg::wb_sel_t                   wbsel_wb_o,
	output logic                                regwen_wb_o,
	output logic [pipe_pkg::REG_IDX_W-1:0]      rd_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           inst_wb_o,
	output logic                                csr_we_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           csr_waddr_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           csr_rdata_wb_o
);

	logic                      done;
	logic [pipe_pkg::XLEN-1:0] mem_data;

	// cache traffic owns the bus whenever it asks
	assign cs_o = dc_bus_req_i || uc_bus_req_i;
	assign we_o = dc_bus_req_i ? dc_bus_we_i : uc_bus_we_i;
	assign addr_o = dc_bus_req_i ? dc_bus_addr_i : addr_i;
	assign wdata_o = dc_bus_req_i ? dc_bus_wdata_i :
		{{(dmem_pkg::LINE_W - pipe_pkg::XLEN){1'b0}}, wdata_i};

	// completion of whichever path this access took
	assign done = cached_i ? dc_ready_i : uc_done_i;
	assign stall_o = access_i && !done;
	assign mem_data = !done ? '0 : (cached_i ? dc_rdata_i : uc_rdata_i);

	// writeback control
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wbsel_wb_o  <= pipe_pkg::WB_ALU;
			regwen_wb_o <= 1'b0;
			csr_we_wb_o <= 1'b0;
		end else if (enable_i) begin
			wbsel_wb_o  <= flush_i ? pipe_pkg::WB_ALU : wbsel_i;
			regwen_wb_o <= !flush_i && regwen_i;
			csr_we_wb_o <= !flush_i && csr_we_i;
		end
	end

	// writeback payload, zeroed on flush
	always_ff @(posedge clk_i) begin
		if (enable_i) begin
			alu_wb_o       <= flush_i ? '0 : alu_i;
			pc4_wb_o       <= flush_i ? '0 : pc4_i;
			mem_wb_o       <= flush_i ? '0 : mem_data;
			rd_wb_o        <= flush_i ? '0 : rd_i;
			inst_wb_o      <= flush_i ? '0 : inst_i;
			csr_waddr_wb_o <= flush_i ? '0 : csr_waddr_i;
			csr_rdata_wb_o <= flush_i ? '0 : csr_rdata_i;
		end
	end

	// both paths come from one instruction, so they never compete
	a_one_bus_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(dc_bus_req_i && uc_bus_req_i));

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
	input  wire logic                           clk_i,
	input  wire logic                           rst_ni,
	input  wire logic                           enable_i,
	input  wire logic                           flush_i,
	input  wire logic                           icache_stall_i,
	input  wire logic                           req_valid_i,
	input  wire logic                           mem_we_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      alu_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      rs2_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      pc4_i,
	input  wire pipe_pkg::wb_sel_t              wbsel_i,
	input  wire logic                           regwen_i,
	input  wire logic [pipe_pkg::REG_IDX_W-1:0] rd_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      inst_i,
	input  wire logic                           csr_we_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      csr_waddr_i,
	input  wire logic [pipe_pkg::XLEN-1:0]      csr_rdata_i,
	input  wire logic [dmem_pkg::LINE_W-1:0]    mem_rdata_i,
	input  wire logic                           mem_rvalid_i,
	output logic                                cs_o,
	output logic                                we_o,
	output logic [dmem_pkg::ADDR_W-1:0]         addr_o,
	output logic [dmem_pkg::LINE_W-1:0]         wdata_o,
	output logic                                stall_o,
	output logic [pipe_pkg::XLEN-1:0]           alu_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           pc4_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           mem_wb_o,
	output pipe_pkg::wb_sel_t                   wbsel_wb_o,
	output logic                                regwen_wb_o,
	output logic [pipe_pkg::REG_IDX_W-1:0]      rd_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           inst_wb_o,
	output logic                                csr_we_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           csr_waddr_wb_o,
	output logic [pipe_pkg::XLEN-1:0]           csr_rdata_wb_o
);

	logic                            access;
	logic                            cached;
	logic                            dc_req_valid;
	logic                            uc_req_valid;
	logic                            dc_ready;
	logic [pipe_pkg::XLEN-1:0]       dc_rdata;
	logic                            dc_bus_req;
	logic                            dc_bus_we;
	logic [dmem_pkg::ADDR_W-1:0]     dc_bus_addr;
	logic [dmem_pkg::LINE_W-1:0]     dc_bus_wdata;
	logic                            uc_bus_req;
	logic                            uc_bus_we;
	logic                            uc_done;
	logic [pipe_pkg::XLEN-1:0]       uc_rdata;

	// an instruction miss freezes the memory access too
	assign access = req_valid_i && !icache_stall_i;
	assign cached = (alu_i[dmem_pkg::REGION_MSB -: 4] == dmem_pkg::CACHED_REGION);
	assign dc_req_valid = access && cached;
	assign uc_req_valid = access && !cached;

	dcache u_dcache (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.req_valid_i  (dc_req_valid),
		.req_we_i     (mem_we_i),
		.req_addr_i   (alu_i),
		.req_wdata_i  (rs2_i),
		.ready_o      (dc_ready),
		.rdata_o      (dc_rdata),
		.bus_req_o    (dc_bus_req),
		.bus_we_o     (dc_bus_we),
		.bus_addr_o   (dc_bus_addr),
		.bus_wdata_o  (dc_bus_wdata),
		.bus_rvalid_i (mem_rvalid_i),
		.bus_rdata_i  (mem_rdata_i)
	);

	uncached_port u_uncached_port (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.req_valid_i  (uc_req_valid),
		.req_we_i     (mem_we_i),
		.bus_rvalid_i (mem_rvalid_i),
		.bus_rdata_i  (mem_rdata_i),
		.bus_req_o    (uc_bus_req),
		.bus_we_o     (uc_bus_we),
		.done_o       (uc_done),
		.rdata_o      (uc_rdata)
	);

	mem_stage_join u_join (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.enable_i       (enable_i),
		.flush_i        (flush_i),
		.access_i       (access),
		.cached_i       (cached),
		.addr_i         (alu_i),
		.wdata_i        (rs2_i),
		.dc_bus_req_i   (dc_bus_req),
		.dc_bus_we_i    (dc_bus_we),
		.dc_bus_addr_i  (dc_bus_addr),
		.dc_bus_wdata_i (dc_bus_wdata),
		.dc_ready_i     (dc_ready),
		.dc_rdata_i     (dc_rdata),
		.uc_bus_req_i   (uc_bus_req),
		.uc_bus_we_i    (uc_bus_we),
		.uc_done_i      (uc_done),
		.uc_rdata_i     (uc_rdata),
		.alu_i          (alu_i),
		.pc4_i          (pc4_i),
		.wbsel_i        (wbsel_i),
		.regwen_i       (regwen_i),
		.rd_i           (rd_i),
		.inst_i         (inst_i),
		.csr_we_i       (csr_we_i),
		.csr_waddr_i    (csr_waddr_i),
		.csr_rdata_i    (csr_rdata_i),
		.cs_o           (cs_o),
		.we_o           (we_o),
		.addr_o         (addr_o),
		.wdata_o        (wdata_o),
		.stall_o        (stall_o),
		.alu_wb_o       (alu_wb_o),
		.pc4_wb_o       (pc4_wb_o),
		.mem_wb_o       (mem_wb_o),
		.wbsel_wb_o     (wbsel_wb_o),
		.regwen_wb_o    (regwen_wb_o),
		.rd_wb_o        (rd_wb_o),
		.inst_wb_o      (inst_wb_o),
		.csr_we_wb_o    (csr_we_wb_o),
		.csr_waddr_wb_o (csr_waddr_wb_o),
		.csr_rdata_wb_o (csr_rdata_wb_o)
	);

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_model (
	input  wire logic         clk_i,
	input  wire logic         rst_ni,
	input  wire logic         cs_i,
	input  wire logic         we_i,
	input  wire logic [31:0]  addr_i,
	input  wire logic [127:0] wdata_i,
	output logic              rvalid_o,
	output logic [127:0]      rdata_o
);

	localparam int unsigned LINES = 1024;
	localparam logic [31:0] SEED = 32'd99652;

	logic [127:0]     data_q [LINES];
	logic [27:0]      ltag_q [LINES];
	logic [LINES-1:0] lvalid_q;
	logic [31:0]      lfsr_q;
	logic             busy_q;
	logic [2:0]       cnt_q;
	logic [31:0]      raddr_q;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// never written words hold the inverse of their byte address
	function automatic logic [127:0] fill_line(input logic [27:0] la);
		logic [127:0] l;
		for (int w = 0; w < 4; w++) begin
			l[w*32 +: 32] = ~{la, 2'(w), 2'b00};
		end
		return l;
	endfunction

	function automatic logic [127:0] line_of(input logic [31:0] a);
		if (lvalid_q[a[13:4]] && (ltag_q[a[13:4]] == a[31:4])) begin
			return data_q[a[13:4]];
		end
		return fill_line(a[31:4]);
	endfunction

	// device space is word wide, the cached region moves whole lines
	function automatic logic is_word(input logic [31:0] a);
		return a[dmem_pkg::REGION_MSB -: 4] != dmem_pkg::CACHED_REGION;
	endfunction

	always @(posedge clk_i or negedge rst_ni) begin : bus
		logic [31:0]  s;
		logic [1:0]   lat;
		logic [127:0] l;
		if (!rst_ni) begin
			rvalid_o <= 1'b0;
			rdata_o  <= '0;
			busy_q   <= 1'b0;
			cnt_q    <= 3'd0;
			raddr_q  <= '0;
			lfsr_q   <= SEED;
			lvalid_q <= '0;
		end else begin
			rvalid_o <= 1'b0;
			if (cs_i && we_i) begin
				l = line_of(addr_i);
				if (is_word(addr_i)) begin
					l[addr_i[3:2]*32 +: 32] = wdata_i[31:0];
				end else begin
					l = wdata_i;
				end
				data_q[addr_i[13:4]]   <= l;
				ltag_q[addr_i[13:4]]   <= addr_i[31:4];
				lvalid_q[addr_i[13:4]] <= 1'b1;
			end else if (cs_i && !busy_q && !rvalid_o) begin
				// two bits of latency, 2 to 5 cycles
				s = lfsr_step(lfsr_q);
				lat[0] = s[0];
				s = lfsr_step(s);
				lat[1] = s[0];
				lfsr_q  <= s;
				cnt_q   <= {1'b0, lat} + 3'd1;
				busy_q  <= 1'b1;
				raddr_q <= addr_i;
			end else if (busy_q) begin
				if (cnt_q == 3'd0) begin
					l = line_of(raddr_q);
					rdata_o  <= is_word(raddr_q) ? {96'b0, l[raddr_q[3:2]*32 +: 32]} : l;
					rvalid_o <= 1'b1;
					busy_q   <= 1'b0;
				end else begin
					cnt_q <= cnt_q - 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;

	localparam int unsigned N_TESTS = 15;
	localparam int unsigned MAX_WAIT = 50;
	localparam logic [31:0] OP_WRITE = 32'd1;
	localparam logic [31:0] OP_HIT = 32'd2;
	localparam logic [31:0] OP_FLUSH = 32'd3;

	logic clk;
	logic rst_n;
	logic enable;
	logic flush;
	logic icache_stall;
	logic req_valid;
	logic mem_we;
	logic [31:0] alu;
	logic [31:0] rs2;
	logic [31:0] pc4;
	pipe_pkg::wb_sel_t wbsel;
	logic regwen;
	logic [4:0] rd;
	logic [31:0] inst;
	logic csr_we;
	logic [31:0] csr_waddr;
	logic [31:0] csr_rdata;
	logic [127:0] mem_rdata;
	logic mem_rvalid;
	logic cs;
	logic we;
	logic [31:0] addr;
	logic [127:0] wdata;
	logic stall;
	logic [31:0] alu_wb;
	logic [31:0] pc4_wb;
	logic [31:0] mem_wb;
	pipe_pkg::wb_sel_t wbsel_wb;
	logic regwen_wb;
	logic [4:0] rd_wb;
	logic [31:0] inst_wb;
	logic csr_we_wb;
	logic [31:0] csr_waddr_wb;
	logic [31:0] csr_rdata_wb;

	// op, address, write data, expected load value
	logic [31:0] td [0:4*N_TESTS-1];
	int unsigned errors = 0;
	int unsigned test_errs = 0;
	int unsigned n_bad = 0;
	logic timed_out = 1'b0;

	mem_stage uut (
		.clk_i(clk), .rst_ni(rst_n), .enable_i(enable), .flush_i(flush),
		.icache_stall_i(icache_stall), .req_valid_i(req_valid), .mem_we_i(mem_we),
		.alu_i(alu), .rs2_i(rs2), .pc4_i(pc4), .wbsel_i(wbsel), .regwen_i(regwen),
		.rd_i(rd), .inst_i(inst), .csr_we_i(csr_we), .csr_waddr_i(csr_waddr),
		.csr_rdata_i(csr_rdata), .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid),
		.cs_o(cs), .we_o(we), .addr_o(addr), .wdata_o(wdata), .stall_o(stall),
		.alu_wb_o(alu_wb), .pc4_wb_o(pc4_wb), .mem_wb_o(mem_wb), .wbsel_wb_o(wbsel_wb),
		.regwen_wb_o(regwen_wb), .rd_wb_o(rd_wb), .inst_wb_o(inst_wb),
		.csr_we_wb_o(csr_we_wb), .csr_waddr_wb_o(csr_waddr_wb),
		.csr_rdata_wb_o(csr_rdata_wb)
	);

	mem_model u_mem (
		.clk_i(clk), .rst_ni(rst_n), .cs_i(cs), .we_i(we), .addr_i(addr),
		.wdata_i(wdata), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata)
	);

	always #4 clk = ~clk;

	// pass-through fields follow the test number
	function automatic logic [31:0] pc4_of(input int unsigned t);
		return 32'h0000_1000 + (t << 2);
	endfunction

	function automatic logic [31:0] inst_of(input int unsigned t);
		return {t[15:0], 16'h2003};
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic drive_access(input int unsigned t, input logic [31:0] op,
			input logic [31:0] a, input logic [31:0] d);
		req_valid = 1'b1;
		mem_we = (op == OP_WRITE);
		alu = a;
		rs2 = d;
		pc4 = pc4_of(t);
		wbsel = pipe_pkg::wb_sel_t'(t[1:0]);
		regwen = t[1];
		rd = t[4:0] + 5'd1;
		inst = inst_of(t);
		csr_we = t[0];
		csr_waddr = 32'h0000_0300 + t;
		csr_rdata = ~a;
	endtask

	// sample just after each edge, before anything is driven
	task automatic wait_done(output logic ok, output logic bus_used);
		int unsigned n;
		n = 0;
		@(posedge clk);
		#1;
		bus_used = cs;
		while (stall && (n < MAX_WAIT)) begin
			@(posedge clk);
			#1;
			bus_used = bus_used || cs;
			n++;
		end
		ok = !stall;
	endtask

	task automatic check_writeback(input int unsigned t, input logic [31:0] op,
			input logic [31:0] a, input logic [31:0] exp);
		logic z;
		z = (op == OP_FLUSH);
		check_value(alu_wb, z ? 32'd0 : a, "alu_wb_o");
		check_value(pc4_wb, z ? 32'd0 : pc4_of(t), "pc4_wb_o");
		check_value({30'b0, wbsel_wb}, z ? 32'd0 : {30'b0, t[1:0]}, "wbsel_wb_o");
		check_value({31'b0, regwen_wb}, {31'b0, t[1] && !z}, "regwen_wb_o");
		check_value({27'b0, rd_wb}, z ? 32'd0 : {27'b0, t[4:0] + 5'd1}, "rd_wb_o");
		check_value(inst_wb, z ? 32'd0 : inst_of(t), "inst_wb_o");
		check_value({31'b0, csr_we_wb}, {31'b0, t[0] && !z}, "csr_we_wb_o");
		check_value(csr_waddr_wb, z ? 32'd0 : 32'h0000_0300 + t, "csr_waddr_wb_o");
		check_value(csr_rdata_wb, z ? 32'd0 : ~a, "csr_rdata_wb_o");
		if (op != OP_WRITE) begin
			check_value(mem_wb, exp, "mem_wb_o");
		end
	endtask

	task automatic run_test(input int unsigned t);
		logic [31:0] op;
		logic [31:0] a;
		logic ok;
		logic bus_used;
		op = td[4*t];
		a = td[4*t+1];
		test_errs = 0;
		drive_access(t, op, a, td[4*t+2]);
		wait_done(ok, bus_used);
		if (!ok) begin
			$display("test %0d: timeout, stall_o still high after %0d cycles", t, MAX_WAIT);
			errors++;
			n_bad++;
			timed_out = 1'b1;
			req_valid = 1'b0;
		end else begin
			// a hit must not touch the bus
			if (op == OP_HIT) begin
				check_value({31'b0, bus_used}, 32'd0, "cs_o during hit");
			end
			flush = (op == OP_FLUSH);
			enable = 1'b1;
			@(posedge clk);
			#1;
			enable = 1'b0;
			flush = 1'b0;
			req_valid = 1'b0;
			mem_we = 1'b0;
			check_writeback(t, op, a, td[4*t+3]);
			if (test_errs != 0) begin
				n_bad++;
			end
			$display("test %0d op %0d addr %h: %s", t, op, a, (test_errs == 0) ? "ok" : "mismatch");
			// a bubble between accesses lets the uncached pending flag clear
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		enable = 1'b0;
		flush = 1'b0;
		icache_stall = 1'b0;
		req_valid = 1'b0;
		mem_we = 1'b0;
		alu = '0;
		rs2 = '0;
		pc4 = '0;
		wbsel = pipe_pkg::WB_ALU;
		regwen = 1'b0;
		rd = '0;
		inst = '0;
		csr_we = 1'b0;
		csr_waddr = '0;
		csr_rdata = '0;
		$readmemh("dv/mem_testdata.hex", td);
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		// idle outputs out of reset
		check_value({31'b0, cs}, 32'd0, "cs_o after reset");
		check_value({31'b0, we}, 32'd0, "we_o after reset");
		check_value({31'b0, stall}, 32'd0, "stall_o after reset");
		check_value({31'b0, regwen_wb}, 32'd0, "regwen_wb_o after reset");
		check_value({31'b0, csr_we_wb}, 32'd0, "csr_we_wb_o after reset");
		if (test_errs != 0) begin
			n_bad++;
		end
		$display("reset test: %s", (test_errs == 0) ? "ok" : "mismatch");
		for (int unsigned t = 0; (t < N_TESTS) && !timed_out; t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d with errors, %0d failed checks", N_TESTS + 1, n_bad, errors);
		if ((errors == 0) && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/dmem_pkg.sv
hdl/pipe_pkg.sv
hdl/dcache.sv
hdl/uncached_port.sv
hdl/mem_stage_join.sv
hdl/mem_stage.sv
dv/mem_model.sv
dv/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(wildcard hdl/*.sv dv/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) filelist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

check:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf $(OBJ_DIR)

/* dv/mem_testdata.hex */
// op (0 read, 1 write, 2 read that must hit, 3 read with flush)
// address, write data, expected load value
0 00000100 00000000 fffffeff
2 00000100 00000000 fffffeff
1 00000104 cafef00d 00000000
2 00000104 00000000 cafef00d
0 00001104 00000000 ffffeefb
0 00000104 00000000 cafef00d
2 00000108 00000000 fffffef7
1 80000020 12345678 00000000
0 80000020 00000000 12345678
0 90000044 00000000 6fffffbb
1 00000230 a5a55a5a 00000000
2 00000230 00000000 a5a55a5a
3 00000300 00000000 00000000
0 00000034 00000000 ffffffcb
0 00000230 00000000 a5a55a5a
